/* design/rob_pkg.sv */
// reorder buffer shared types
// exception causes, entry states and default sizes

package rob_pkg;

  // ---------------------------------------------------------------------------
  // sizes
  // ---------------------------------------------------------------------------
  localparam int DEFAULT_DISP_SIZE  = 4;  // lanes per dispatch group
  localparam int DEFAULT_ENTRY_SIZE = 8;  // groups held, power of two

  // ---------------------------------------------------------------------------
  // types
  // ---------------------------------------------------------------------------
  typedef logic [31:0] vaddr_t;  // pc, tval and epc

  // exception cause, encoded as the privileged spec mcause values
  typedef enum logic [3:0] {
    INST_ADDR_MISALIGN  = 4'd0,
    INST_ACC_FAULT      = 4'd1,
    ILLEGAL_INST        = 4'd2,
    BREAKPOINT          = 4'd3,
    LOAD_ADDR_MISALIGN  = 4'd4,
    LOAD_ACC_FAULT      = 4'd5,
    STORE_ADDR_MISALIGN = 4'd6,
    STORE_ACC_FAULT     = 4'd7
  } except_t;

  // per-entry life cycle
  typedef enum logic [1:0] {
    ENTRY_FREE = 2'd0,
    ENTRY_WAIT = 2'd1,  // some valid lane not done yet
    ENTRY_DONE = 2'd2   // ready to retire
  } entry_state_t;

endpackage

/* design/rob_dispatch.sv */
// reorder buffer dispatch stage
// turns one dispatch group into the fields of a new entry

`timescale 1ns/1ps

module rob_dispatch
  import rob_pkg::*;
#(
  parameter int DISP_SIZE = DEFAULT_DISP_SIZE
) (
  input  logic                    i_disp_valid,
  input  vaddr_t                  i_disp_pc,
  input  logic    [DISP_SIZE-1:0] i_disp_lane_valid,
  input  logic    [DISP_SIZE-1:0] i_disp_illegal,
  input  logic    [DISP_SIZE-1:0] i_disp_fetch_fault,
  input  except_t [DISP_SIZE-1:0] i_disp_fetch_cause,
  input  logic                    i_commit_flush,  // head is flushing this cycle

  output logic                    o_wr_valid,
  output vaddr_t                  o_wr_pc,
  output logic    [DISP_SIZE-1:0] o_wr_grp,
  output logic    [DISP_SIZE-1:0] o_wr_done,
  output logic    [DISP_SIZE-1:0] o_wr_dead,
  output logic    [DISP_SIZE-1:0] o_wr_except,
  output except_t [DISP_SIZE-1:0] o_wr_cause,
  output vaddr_t  [DISP_SIZE-1:0] o_wr_tval
);

  logic [DISP_SIZE-1:0] w_early_exc;  // lanes that trap before execution

  assign w_early_exc = i_disp_lane_valid & (i_disp_illegal | i_disp_fetch_fault);

  assign o_wr_valid = i_disp_valid;
  assign o_wr_pc    = i_disp_pc;
  assign o_wr_grp   = i_disp_lane_valid;
  assign o_wr_tval  = '0;  // no tval for dispatch-time causes

  // ---------------------------------------------------------------------------
  // per-lane cause, fetch fault wins over illegal
  // ---------------------------------------------------------------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_wr_cause[d] = i_disp_fetch_fault[d] ? i_disp_fetch_cause[d] : ILLEGAL_INST;
    end
  end

  // a group arriving under a flush is stored dead, so it retires quietly
  always_comb begin
    if (i_commit_flush) begin
      o_wr_done   = i_disp_lane_valid;
      o_wr_dead   = i_disp_lane_valid;
      o_wr_except = '0;
    end else begin
      o_wr_done   = w_early_exc;  // trapping lanes never execute
      o_wr_dead   = '0;
      o_wr_except = w_early_exc;
    end
  end

  // an empty group would sit in the buffer as done with nothing to retire
  a_disp_has_lane: assert final (!i_disp_valid || (|i_disp_lane_valid))
    else $error("dispatch strobe without any valid lane");

endmodule

/* design/rob_entry_array.sv */
// reorder buffer entry storage
// write and head pointers, done tracking, head read-out

`timescale 1ns/1ps

module rob_entry_array
  import rob_pkg::*;
#(
  parameter int DISP_SIZE  = DEFAULT_DISP_SIZE,
  parameter int ENTRY_SIZE = DEFAULT_ENTRY_SIZE
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,

  // write port from dispatch
  input  logic                           i_wr_valid,
  input  vaddr_t                         i_wr_pc,
  input  logic    [DISP_SIZE-1:0]        i_wr_grp,
  input  logic    [DISP_SIZE-1:0]        i_wr_done,
  input  logic    [DISP_SIZE-1:0]        i_wr_dead,
  input  logic    [DISP_SIZE-1:0]        i_wr_except,
  input  except_t [DISP_SIZE-1:0]        i_wr_cause,
  input  vaddr_t  [DISP_SIZE-1:0]        i_wr_tval,

  // done report
  input  logic                           i_done_valid,
  input  logic [$clog2(ENTRY_SIZE):0]    i_done_cmt_id,
  input  logic [$clog2(DISP_SIZE)-1:0]   i_done_lane,
  input  logic                           i_done_except,
  input  except_t                        i_done_cause,
  input  vaddr_t                         i_done_tval,

  output logic [$clog2(ENTRY_SIZE):0]    o_new_cmt_id,

  // head read-out
  output logic                           o_head_ready,
  output logic [$clog2(ENTRY_SIZE):0]    o_head_cmt_id,
  output vaddr_t                         o_head_pc,
  output logic    [DISP_SIZE-1:0]        o_head_grp,
  output logic    [DISP_SIZE-1:0]        o_head_dead,
  output logic    [DISP_SIZE-1:0]        o_head_except,
  output except_t [DISP_SIZE-1:0]        o_head_cause,
  output vaddr_t  [DISP_SIZE-1:0]        o_head_tval
);

  localparam int IDX_W = $clog2(ENTRY_SIZE);

  entry_state_t            r_state [ENTRY_SIZE];
  logic [IDX_W:0]          r_wr_ptr;    // top bit is the wrap bit
  logic [IDX_W:0]          r_head_ptr;
  vaddr_t                  r_pc     [ENTRY_SIZE];
  logic [DISP_SIZE-1:0]    r_grp    [ENTRY_SIZE];
  logic [DISP_SIZE-1:0]    r_done   [ENTRY_SIZE];
  logic [DISP_SIZE-1:0]    r_dead   [ENTRY_SIZE];
  logic [DISP_SIZE-1:0]    r_except [ENTRY_SIZE];
  except_t [DISP_SIZE-1:0] r_cause  [ENTRY_SIZE];
  vaddr_t  [DISP_SIZE-1:0] r_tval   [ENTRY_SIZE];

  logic [IDX_W-1:0]        w_wr_idx;
  logic [IDX_W-1:0]        w_head_idx;
  logic [IDX_W-1:0]        w_done_idx;
  logic [DISP_SIZE-1:0]    w_done_lane_oh;
  logic                    w_wr_all_done;    // new group needs no reports
  logic                    w_done_all_done;  // report completes its group
  logic                    w_full;

  assign w_wr_idx   = r_wr_ptr[IDX_W-1:0];
  assign w_head_idx = r_head_ptr[IDX_W-1:0];
  assign w_done_idx = i_done_cmt_id[IDX_W-1:0];

  assign w_done_lane_oh  = DISP_SIZE'(1) << i_done_lane;
  assign w_wr_all_done   = &(i_wr_done | ~i_wr_grp);
  assign w_done_all_done = &(r_done[w_done_idx] | w_done_lane_oh | ~r_grp[w_done_idx]);
  assign w_full = (w_wr_idx == w_head_idx) && (r_wr_ptr[IDX_W] != r_head_ptr[IDX_W]);

  // ---------------------------------------------------------------------------
  // pointers and entry state
  // ---------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr   <= '0;
      r_head_ptr <= '0;
      for (int e = 0; e < ENTRY_SIZE; e++) begin
        r_state[e] <= ENTRY_FREE;
      end
    end else begin
      if (i_wr_valid) begin
        r_wr_ptr          <= r_wr_ptr + 1'b1;
        r_state[w_wr_idx] <= w_wr_all_done ? ENTRY_DONE : ENTRY_WAIT;
      end
      if (i_done_valid && w_done_all_done) begin
        r_state[w_done_idx] <= ENTRY_DONE;
      end
      if (o_head_ready) begin  // retire and free the head
        r_head_ptr          <= r_head_ptr + 1'b1;
        r_state[w_head_idx] <= ENTRY_FREE;
      end
    end
  end

  // group payload and per-lane status
  always_ff @(posedge i_clk) begin
    if (i_wr_valid) begin
      r_pc[w_wr_idx]     <= i_wr_pc;
      r_grp[w_wr_idx]    <= i_wr_grp;
      r_done[w_wr_idx]   <= i_wr_done;
      r_dead[w_wr_idx]   <= i_wr_dead;
      r_except[w_wr_idx] <= i_wr_except;
      r_cause[w_wr_idx]  <= i_wr_cause;
      r_tval[w_wr_idx]   <= i_wr_tval;
    end
    if (i_done_valid) begin
      r_done[w_done_idx] <= r_done[w_done_idx] | w_done_lane_oh;
      if (i_done_except) begin
        r_except[w_done_idx][i_done_lane] <= 1'b1;
        r_cause[w_done_idx][i_done_lane]  <= i_done_cause;
        r_tval[w_done_idx][i_done_lane]   <= i_done_tval;
      end
    end
  end

  assign o_new_cmt_id  = r_wr_ptr;
  assign o_head_ready  = (r_state[w_head_idx] == ENTRY_DONE);
  assign o_head_cmt_id = r_head_ptr;
  assign o_head_pc     = r_pc[w_head_idx];
  assign o_head_grp    = r_grp[w_head_idx];
  assign o_head_dead   = r_dead[w_head_idx];
  assign o_head_except = r_except[w_head_idx];
  assign o_head_cause  = r_cause[w_head_idx];
  assign o_head_tval   = r_tval[w_head_idx];

  // ---------------------------------------------------------------------------
  // protocol checks
  // ---------------------------------------------------------------------------
  a_no_wr_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_valid |-> !w_full)
    else $error("dispatch into a full reorder buffer");

  a_done_wait: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_done_valid |-> (r_state[w_done_idx] == ENTRY_WAIT))
    else $error("done report for an entry not waiting");

  a_done_lane: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_done_valid |-> r_grp[w_done_idx][i_done_lane])
    else $error("done report for an invalid lane");

endmodule

/* design/rob_commit.sv */
// reorder buffer commit stage
// picks the excepting lane and builds the commit report

`timescale 1ns/1ps

module rob_commit
  import rob_pkg::*;
#(
  parameter int DISP_SIZE  = DEFAULT_DISP_SIZE,
  parameter int ENTRY_SIZE = DEFAULT_ENTRY_SIZE
) (
  input  logic                          i_head_ready,
  input  logic [$clog2(ENTRY_SIZE):0]   i_head_cmt_id,
  input  vaddr_t                        i_head_pc,
  input  logic    [DISP_SIZE-1:0]       i_head_grp,
  input  logic    [DISP_SIZE-1:0]       i_head_dead,
  input  logic    [DISP_SIZE-1:0]       i_head_except,
  input  except_t [DISP_SIZE-1:0]       i_head_cause,
  input  vaddr_t  [DISP_SIZE-1:0]       i_head_tval,

  output logic                          o_commit,
  output logic [$clog2(ENTRY_SIZE):0]   o_commit_cmt_id,
  output logic    [DISP_SIZE-1:0]       o_commit_grp,
  output logic    [DISP_SIZE-1:0]       o_commit_dead,
  output logic    [DISP_SIZE-1:0]       o_commit_except,  // one-hot lane
  output except_t                       o_commit_cause,
  output vaddr_t                        o_commit_tval,
  output vaddr_t                        o_commit_epc,
  output logic                          o_commit_flush
);

  localparam int LANE_W = $clog2(DISP_SIZE);

  logic [DISP_SIZE-1:0] w_exc_lanes;  // live excepting lanes
  logic [DISP_SIZE-1:0] w_sel_oh;
  logic [DISP_SIZE-1:0] w_kill;       // lanes younger than the selected one
  logic [LANE_W-1:0]    w_sel_lane;
  logic                 w_found;
  except_t              w_cause;
  vaddr_t               w_epc;

  assign w_exc_lanes = i_head_except & ~i_head_dead;

  // ---------------------------------------------------------------------------
  // lowest excepting lane wins and everything above it dies
  // ---------------------------------------------------------------------------
  always_comb begin
    w_found    = 1'b0;
    w_sel_lane = '0;
    w_sel_oh   = '0;
    w_kill     = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (w_found) begin
        w_kill[d] = 1'b1;
      end else if (w_exc_lanes[d]) begin
        w_found     = 1'b1;
        w_sel_lane  = LANE_W'(d);
        w_sel_oh[d] = 1'b1;
      end
    end
  end

  assign w_cause = i_head_cause[w_sel_lane];
  assign w_epc   = i_head_pc + (vaddr_t'(w_sel_lane) << 2);  // 4 bytes per lane

  assign o_commit        = i_head_ready;
  assign o_commit_cmt_id = i_head_cmt_id;
  assign o_commit_grp    = i_head_grp;
  assign o_commit_dead   = (i_head_dead | w_kill) & i_head_grp & {DISP_SIZE{i_head_ready}};
  assign o_commit_except = w_sel_oh & {DISP_SIZE{i_head_ready}};
  assign o_commit_cause  = w_cause;
  assign o_commit_epc    = w_epc;
  assign o_commit_flush  = i_head_ready & w_found;

  // fetch-side faults report the faulting address itself
  assign o_commit_tval = ((w_cause == INST_ADDR_MISALIGN) || (w_cause == INST_ACC_FAULT)) ?
                         w_epc : i_head_tval[w_sel_lane];

  // exception bits come from dispatch and done reports, both tied to valid lanes
  a_except_valid_lane: assert final ((o_commit_except & ~i_head_grp) == '0)
    else $error("commit reports an exception on a lane outside the group");

endmodule

/* design/rob_top.sv */
// reorder buffer top level
// dispatch, entry array and commit

`timescale 1ns/1ps

module rob_top
  import rob_pkg::*;
#(
  parameter int DISP_SIZE  = DEFAULT_DISP_SIZE,
  parameter int ENTRY_SIZE = DEFAULT_ENTRY_SIZE
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  input  logic                          i_disp_valid,
  input  vaddr_t                        i_disp_pc,
  input  logic    [DISP_SIZE-1:0]       i_disp_lane_valid,
  input  logic    [DISP_SIZE-1:0]       i_disp_illegal,
  input  logic    [DISP_SIZE-1:0]       i_disp_fetch_fault,
  input  except_t [DISP_SIZE-1:0]       i_disp_fetch_cause,

  input  logic                          i_done_valid,
  input  logic [$clog2(ENTRY_SIZE):0]   i_done_cmt_id,
  input  logic [$clog2(DISP_SIZE)-1:0]  i_done_lane,
  input  logic                          i_done_except,
  input  except_t                       i_done_cause,
  input  vaddr_t                        i_done_tval,

  output logic [$clog2(ENTRY_SIZE):0]   o_new_cmt_id,

  output logic                          o_commit,
  output logic [$clog2(ENTRY_SIZE):0]   o_commit_cmt_id,
  output logic    [DISP_SIZE-1:0]       o_commit_grp,
  output logic    [DISP_SIZE-1:0]       o_commit_dead,
  output logic    [DISP_SIZE-1:0]       o_commit_except,
  output except_t                       o_commit_cause,
  output vaddr_t                        o_commit_tval,
  output vaddr_t                        o_commit_epc,
  output logic                          o_commit_flush
);

  // dispatch to array
  logic                        w_wr_valid;
  vaddr_t                      w_wr_pc;
  logic    [DISP_SIZE-1:0]     w_wr_grp;
  logic    [DISP_SIZE-1:0]     w_wr_done;
  logic    [DISP_SIZE-1:0]     w_wr_dead;
  logic    [DISP_SIZE-1:0]     w_wr_except;
  except_t [DISP_SIZE-1:0]     w_wr_cause;
  vaddr_t  [DISP_SIZE-1:0]     w_wr_tval;

  // array to commit
  logic                        w_head_ready;
  logic [$clog2(ENTRY_SIZE):0] w_head_cmt_id;
  vaddr_t                      w_head_pc;
  logic    [DISP_SIZE-1:0]     w_head_grp;
  logic    [DISP_SIZE-1:0]     w_head_dead;
  logic    [DISP_SIZE-1:0]     w_head_except;
  except_t [DISP_SIZE-1:0]     w_head_cause;
  vaddr_t  [DISP_SIZE-1:0]     w_head_tval;

  rob_dispatch #(.DISP_SIZE(DISP_SIZE)) u_dispatch (
    .i_disp_valid      (i_disp_valid),
    .i_disp_pc         (i_disp_pc),
    .i_disp_lane_valid (i_disp_lane_valid),
    .i_disp_illegal    (i_disp_illegal),
    .i_disp_fetch_fault(i_disp_fetch_fault),
    .i_disp_fetch_cause(i_disp_fetch_cause),
    .i_commit_flush    (o_commit_flush),  // kills a group arriving with the flush
    .o_wr_valid        (w_wr_valid),
    .o_wr_pc           (w_wr_pc),
    .o_wr_grp          (w_wr_grp),
    .o_wr_done         (w_wr_done),
    .o_wr_dead         (w_wr_dead),
    .o_wr_except       (w_wr_except),
    .o_wr_cause        (w_wr_cause),
    .o_wr_tval         (w_wr_tval)
  );

  rob_entry_array #(.DISP_SIZE(DISP_SIZE), .ENTRY_SIZE(ENTRY_SIZE)) u_entry_array (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_wr_valid   (w_wr_valid),
    .i_wr_pc      (w_wr_pc),
    .i_wr_grp     (w_wr_grp),
    .i_wr_done    (w_wr_done),
    .i_wr_dead    (w_wr_dead),
    .i_wr_except  (w_wr_except),
    .i_wr_cause   (w_wr_cause),
    .i_wr_tval    (w_wr_tval),
    .i_done_valid (i_done_valid),
    .i_done_cmt_id(i_done_cmt_id),
    .i_done_lane  (i_done_lane),
    .i_done_except(i_done_except),
    .i_done_cause (i_done_cause),
    .i_done_tval  (i_done_tval),
    .o_new_cmt_id (o_new_cmt_id),
    .o_head_ready (w_head_ready),
    .o_head_cmt_id(w_head_cmt_id),
    .o_head_pc    (w_head_pc),
    .o_head_grp   (w_head_grp),
    .o_head_dead  (w_head_dead),
    .o_head_except(w_head_except),
    .o_head_cause (w_head_cause),
    .o_head_tval  (w_head_tval)
  );

  rob_commit #(.DISP_SIZE(DISP_SIZE), .ENTRY_SIZE(ENTRY_SIZE)) u_commit (
    .i_head_ready   (w_head_ready),
    .i_head_cmt_id  (w_head_cmt_id),
    .i_head_pc      (w_head_pc),
    .i_head_grp     (w_head_grp),
    .i_head_dead    (w_head_dead),
    .i_head_except  (w_head_except),
    .i_head_cause   (w_head_cause),
    .i_head_tval    (w_head_tval),
    .o_commit       (o_commit),
    .o_commit_cmt_id(o_commit_cmt_id),
    .o_commit_grp   (o_commit_grp),
    .o_commit_dead  (o_commit_dead),
    .o_commit_except(o_commit_except),
    .o_commit_cause (o_commit_cause),
    .o_commit_tval  (o_commit_tval),
    .o_commit_epc   (o_commit_epc),
    .o_commit_flush (o_commit_flush)
  );

endmodule

/* dv/rob_tb_clock.sv */
// testbench clock and reset

`timescale 1ns/1ps

module rob_tb_clock #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 8
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;  // release away from the active edge
  end

endmodule

/* dv/rob_tb.sv */
// reorder buffer testbench

`timescale 1ns/1ps

module rob_tb
  import rob_pkg::*;
();

  localparam int DISP    = DEFAULT_DISP_SIZE;
  localparam int ENTRY   = DEFAULT_ENTRY_SIZE;
  localparam int ID_W    = $clog2(ENTRY) + 1;
  localparam int LANE_W  = $clog2(DISP);
  localparam int N_TESTS = 6;

  typedef struct {
    int              test;
    int              dcyc;    // dispatch cycle within the test
    int              rcyc;    // cycle of the first done report
    vaddr_t          pc;
    logic [DISP-1:0] valid, illegal, fault;
    except_t         fcause;
    int              xlane;   // lane with an execution exception or -1
    except_t         xcause;
    vaddr_t          xtval;
    bit              killed;  // arrives together with a flush
  } grp_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [DISP-1:0] grp, dead, exc;
    except_t         cause;
    vaddr_t          tval, epc;
    logic            flush;
  } exp_t;

  logic               clk, reset_n;
  logic               disp_valid, done_valid, done_except;
  vaddr_t             disp_pc, done_tval;
  logic [DISP-1:0]    disp_lane_valid, disp_illegal, disp_fetch_fault;
  except_t [DISP-1:0] disp_fetch_cause;
  logic [ID_W-1:0]    done_cmt_id, new_cmt_id, commit_cmt_id;
  logic [LANE_W-1:0]  done_lane;
  except_t            done_cause, commit_cause;
  logic               commit, commit_flush;
  logic [DISP-1:0]    commit_grp, commit_dead, commit_except;
  vaddr_t             commit_tval, commit_epc;

  grp_t            grp_q[$];
  exp_t            exp_q[$];   // commits still to come in order
  string           names[N_TESTS];
  string           cur_name = "reset";
  logic [ID_W-1:0] next_id = '0;
  logic [ID_W-1:0] disp_id = '0;  // id the group on the dispatch port should get
  logic [31:0]     lfsr_state = 32'h7406_a3de;
  int              n_checks = 0;
  int              n_errors = 0;
  int              cycle_cnt = 0;
  int              cycle_limit = 1000;

  rob_tb_clock #(.PERIOD_NS(4.0), .RESET_CYCLES(8)) u_clock (.o_clk(clk), .o_reset_n(reset_n));

  rob_top #(.DISP_SIZE(DISP), .ENTRY_SIZE(ENTRY)) i_rob_top (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_disp_valid(disp_valid), .i_disp_pc(disp_pc), .i_disp_lane_valid(disp_lane_valid),
    .i_disp_illegal(disp_illegal), .i_disp_fetch_fault(disp_fetch_fault),
    .i_disp_fetch_cause(disp_fetch_cause),
    .i_done_valid(done_valid), .i_done_cmt_id(done_cmt_id), .i_done_lane(done_lane),
    .i_done_except(done_except), .i_done_cause(done_cause), .i_done_tval(done_tval),
    .o_new_cmt_id(new_cmt_id),
    .o_commit(commit), .o_commit_cmt_id(commit_cmt_id), .o_commit_grp(commit_grp),
    .o_commit_dead(commit_dead), .o_commit_except(commit_except),
    .o_commit_cause(commit_cause), .o_commit_tval(commit_tval),
    .o_commit_epc(commit_epc), .o_commit_flush(commit_flush)
  );

  // --------------------------------------------------------------------------
  // test table
  // --------------------------------------------------------------------------
  task automatic add_group(input int test, input int dcyc, input int rcyc, input vaddr_t pc,
                           input logic [DISP-1:0] valid, input logic [DISP-1:0] illegal,
                           input logic [DISP-1:0] fault, input except_t fcause,
                           input int xlane, input except_t xcause, input vaddr_t xtval,
                           input bit killed);
    grp_t g;
    g = '{test, dcyc, rcyc, pc, valid, illegal, fault, fcause, xlane, xcause, xtval, killed};
    grp_q.push_back(g);
  endtask

  task automatic build_table();
    names = '{"in_order", "illegal_lane", "fetch_fault", "exec_exception",
              "flush_dispatch", "pointer_wrap"};
    // reports of the youngest group arrive first
    add_group(0, 0, 7, 32'h1000, 4'hf, 4'h0, 4'h0, ILLEGAL_INST, -1, ILLEGAL_INST, 0, 1'b0);
    add_group(0, 1, 11, 32'h1010, 4'h7, 4'h0, 4'h0, ILLEGAL_INST, -1, ILLEGAL_INST, 0, 1'b0);
    add_group(0, 2, 3, 32'h1020, 4'hf, 4'h0, 4'h0, ILLEGAL_INST, -1, ILLEGAL_INST, 0, 1'b0);
    add_group(1, 0, 1, 32'h2000, 4'hf, 4'h2, 4'h0, ILLEGAL_INST, -1, ILLEGAL_INST, 0, 1'b0);
    add_group(2, 0, 1, 32'h3000, 4'hf, 4'h0, 4'h4, INST_ACC_FAULT, -1, ILLEGAL_INST, 0, 1'b0);
    add_group(3, 0, 1, 32'h4000, 4'h7, 4'h0, 4'h0, ILLEGAL_INST, 0, LOAD_ACC_FAULT,
              32'hdead_0010, 1'b0);
    add_group(4, 0, 1, 32'h5000, 4'h3, 4'h0, 4'h0, ILLEGAL_INST, 1, STORE_ACC_FAULT,
              32'h5000_0040, 1'b0);
    add_group(4, 3, 0, 32'h5010, 4'h7, 4'h0, 4'h0, ILLEGAL_INST, -1, ILLEGAL_INST, 0, 1'b1);
    for (int i = 0; i < ENTRY + 2; i++) begin  // one group in flight at a time
      add_group(5, 2 * i, 2 * i + 1, 32'h6000 + vaddr_t'(16 * i), 4'h1, 4'h0, 4'h0,
                ILLEGAL_INST, -1, ILLEGAL_INST, 0, 1'b0);
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_below(input int m);
    int v;
    v = 0;
    for (int b = 0; b < 2; b++) begin
      v = (v << 1) | int'(next_rand_bit());
    end
    return v % m;
  endfunction

  function automatic int test_len(input int t);
    int len;
    len = 0;
    foreach (grp_q[k]) begin
      if (grp_q[k].test == t) begin
        len = (grp_q[k].dcyc + 1 > len) ? grp_q[k].dcyc + 1 : len;
        if (!grp_q[k].killed && grp_q[k].rcyc + $countones(grp_q[k].valid &
            ~(grp_q[k].illegal | grp_q[k].fault)) > len) begin
          len = grp_q[k].rcyc + $countones(grp_q[k].valid & ~(grp_q[k].illegal | grp_q[k].fault));
        end
      end
    end
    return len;
  endfunction

  // --------------------------------------------------------------------------
  // commit model
  // --------------------------------------------------------------------------
  function automatic exp_t expect_commit(input grp_t g, input logic [ID_W-1:0] id);
    exp_t            e;
    logic [DISP-1:0] exc;
    int              sel;
    e   = '0;
    sel = -1;
    exc = g.valid & (g.illegal | g.fault);  // trapped before execution
    if (g.xlane >= 0) exc[g.xlane] = 1'b1;
    if (g.killed) exc = '0;
    e.id   = id;
    e.grp  = g.valid;
    e.dead = g.killed ? g.valid : '0;
    for (int d = 0; d < DISP; d++) begin
      if (sel >= 0 && g.valid[d]) begin
        e.dead[d] = 1'b1;  // younger than the trapping lane
      end else if (sel < 0 && exc[d]) begin
        sel = d;
      end
    end
    if (sel >= 0) begin
      e.exc[sel] = 1'b1;
      e.flush    = 1'b1;
      e.cause    = g.fault[sel] ? g.fcause : (g.illegal[sel] ? ILLEGAL_INST : g.xcause);
      e.epc      = g.pc + vaddr_t'(4 * sel);
      if (e.cause inside {INST_ADDR_MISALIGN, INST_ACC_FAULT}) begin
        e.tval = e.epc;
      end else if (sel == g.xlane) begin
        e.tval = g.xtval;
      end
    end
    return e;
  endfunction

  task automatic compare_field(input string field, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    n_checks++;
    if (exp_v !== act_v) begin
      n_errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", cur_name, field, exp_v, act_v);
    end
  endtask

  task automatic idle_inputs();
    disp_valid       <= 1'b0;
    disp_pc          <= '0;
    disp_lane_valid  <= '0;
    disp_illegal     <= '0;
    disp_fetch_fault <= '0;
    for (int d = 0; d < DISP; d++) begin
      disp_fetch_cause[d] <= INST_ADDR_MISALIGN;
    end
    done_valid  <= 1'b0;
    done_cmt_id <= '0;
    done_lane   <= '0;
    done_except <= 1'b0;
    done_cause  <= INST_ADDR_MISALIGN;
    done_tval   <= '0;
  endtask

  // --------------------------------------------------------------------------
  // driver for one table test
  // --------------------------------------------------------------------------
  task automatic run_test(input int t);
    int              gi[$];
    logic [ID_W-1:0] gid[$];
    int              rep_cyc[$];
    int              rep_grp[$];
    int              rep_lane[$];
    int              lanes[$];
    int              errs_at_start;
    int              len;
    int              r;
    int              tmp;
    grp_t            g;
    cur_name      = names[t];
    errs_at_start = n_errors;
    len           = test_len(t);
    foreach (grp_q[k]) begin
      if (grp_q[k].test == t) begin
        gid.push_back(next_id + ID_W'(gi.size()));  // ids follow dispatch order
        gi.push_back(k);
      end
    end
    foreach (gi[k]) begin
      g = grp_q[gi[k]];
      lanes.delete();
      for (int d = 0; d < DISP; d++) begin
        if (g.valid[d] && !g.illegal[d] && !g.fault[d] && !g.killed) lanes.push_back(d);
      end
      for (int j = lanes.size() - 1; j > 0; j--) begin  // scramble lane order
        r        = rand_below(j + 1);
        tmp      = lanes[j];
        lanes[j] = lanes[r];
        lanes[r] = tmp;
      end
      foreach (lanes[n]) begin
        rep_cyc.push_back(g.rcyc + n);
        rep_grp.push_back(k);
        rep_lane.push_back(lanes[n]);
      end
    end
    for (int c = 0; c < len; c++) begin
      @(posedge clk);
      idle_inputs();
      foreach (gi[k]) begin
        g = grp_q[gi[k]];
        if (g.dcyc == c) begin
          disp_valid       <= 1'b1;
          disp_pc          <= g.pc;
          disp_lane_valid  <= g.valid;
          disp_illegal     <= g.illegal;
          disp_fetch_fault <= g.fault;
          for (int d = 0; d < DISP; d++) begin
            disp_fetch_cause[d] <= g.fcause;
          end
          disp_id = gid[k];
          exp_q.push_back(expect_commit(g, gid[k]));
        end
      end
      foreach (rep_cyc[n]) begin
        if (rep_cyc[n] == c) begin
          g = grp_q[gi[rep_grp[n]]];
          done_valid  <= 1'b1;
          done_cmt_id <= gid[rep_grp[n]];
          done_lane   <= LANE_W'(rep_lane[n]);
          done_except <= (rep_lane[n] == g.xlane);
          done_cause  <= g.xcause;
          done_tval   <= g.xtval;
        end
      end
    end
    @(posedge clk);
    idle_inputs();
    next_id = next_id + ID_W'(gi.size());
    while (exp_q.size() != 0) @(posedge clk);
    $display("%-15s %s, %0d errors", cur_name, (n_errors == errs_at_start) ? "ok" : "FAIL",
             n_errors - errs_at_start);
  endtask

  // commit outputs are stable around the falling edge
  always @(negedge clk) begin : commit_monitor
    exp_t e;
    if (reset_n && disp_valid) begin
      compare_field("new_cmt_id", 32'(disp_id), 32'(new_cmt_id));
    end
    if (reset_n && commit) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("%s: commit of id %0h while no group is outstanding", cur_name, commit_cmt_id);
      end else begin
        e = exp_q.pop_front();
        compare_field("cmt_id", 32'(e.id), 32'(commit_cmt_id));
        compare_field("grp", 32'(e.grp), 32'(commit_grp));
        compare_field("dead", 32'(e.dead), 32'(commit_dead));
        compare_field("except", 32'(e.exc), 32'(commit_except));
        compare_field("flush", 32'(e.flush), 32'(commit_flush));
        if (e.flush) begin
          compare_field("cause", 32'(e.cause), 32'(commit_cause));
          compare_field("tval", e.tval, commit_tval);
          compare_field("epc", e.epc, commit_epc);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles with %0d commits missing", cycle_cnt, exp_q.size());
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    int total;
    idle_inputs();
    build_table();
    total = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      total += test_len(t);
    end
    cycle_limit = total + 200;
    @(posedge reset_n);
    @(negedge clk);
    compare_field("commit", 32'h0, 32'(commit));
    compare_field("flush", 32'h0, 32'(commit_flush));
    compare_field("except", 32'h0, 32'(commit_except));
    compare_field("dead", 32'h0, 32'(commit_dead));
    compare_field("new_cmt_id", 32'h0, 32'(new_cmt_id));
    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* project.f */
design/rob_pkg.sv
design/rob_dispatch.sv
design/rob_entry_array.sv
design/rob_commit.sv
design/rob_top.sv
dv/rob_tb_clock.sv
dv/rob_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module rob_tb -f project.f -o rob_sim

out=$(./obj_dir/rob_sim) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
